//--- hw/decodePkg.sv
// Decode stage package with field positions, opcodes, sizes and the shared packed structs
`default_nettype none

package decodePkg;

   localparam int dataWidth    = 16;  // Machine word width
   localparam int regCount     = 8;   // General registers R0 to R7
   localparam int regAddrWidth = 3;   // Bits needed to name one register

   // Bit positions of the instruction fields
   localparam int opHi   = 15;  // Five bit major opcode
   localparam int opLo   = 11;
   localparam int grpHi  = 15;  // Three bit prefix shared by all branches
   localparam int grpLo  = 13;
   localparam int condHi = 12;  // Branch condition sits in the low opcode bits
   localparam int condLo = 11;
   localparam int rsHi   = 10;  // First source register
   localparam int rsLo   = 8;
   localparam int rtHi   = 7;   // Second source register
   localparam int rtLo   = 5;

   localparam logic [regAddrWidth-1:0] linkReg = 3'd7;  // Return address goes here

   localparam logic [4:0] opJal  = 5'b00110;  // Jump and link, PC relative
   localparam logic [4:0] opJalr = 5'b00111;  // Jump and link through a register

   localparam logic [2:0] branchGroup = 3'b011;

   // Branch conditions, all tested against Rs
   localparam logic [1:0] condEqz = 2'b00;
   localparam logic [1:0] condNez = 2'b01;
   localparam logic [1:0] condLtz = 2'b10;
   localparam logic [1:0] condGez = 2'b11;

   localparam int linkDepth = 3;  // Decode to writeback is three edges away

   typedef struct packed {
      logic jump;      // Unconditional jump of any kind
      logic halt;      // Halt stops any redirect
      logic regWrite;  // Instruction writes a register later
      logic memRead;
      logic memWrite;
      logic valid;     // Slot holds a real instruction
   } ctrlT;

   typedef struct packed {
      logic                    en;
      logic [regAddrWidth-1:0] addr;
      logic [dataWidth-1:0]    data;
   } wbT;

   typedef struct packed {
      logic valid;  // A jump and link is travelling down the pipe
   } linkRecT;

   typedef struct packed {
      logic [dataWidth-1:0]    reg1Data;
      logic [dataWidth-1:0]    reg2Data;
      logic [dataWidth-1:0]    imm;
      logic [dataWidth-1:0]    pcNow;
      logic [regAddrWidth-1:0] rt;
      ctrlT                    ctrl;
   } idExT;

endpackage

`default_nettype wire

//--- hw/registerFile.sv
// Register file of eight words with two bypassed read ports and one write port
`default_nettype none

module registerFile (
   input  logic                                clk,
   input  logic                                reset,
   input  logic [decodePkg::regAddrWidth-1:0]  readAddr1,
   input  logic [decodePkg::regAddrWidth-1:0]  readAddr2,
   input  decodePkg::wbT                       write,
   output logic [decodePkg::dataWidth-1:0]     readData1,
   output logic [decodePkg::dataWidth-1:0]     readData2
);
   import decodePkg::*;

   logic [dataWidth-1:0] regs [regCount];  // Architectural state
   logic                 hit1;             // Port 1 reads the word being written
   logic                 hit2;

   // Every register comes out of reset as zero
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < regCount; i++) begin
            regs[i] <= '0;
         end
      end else if (write.en) begin
         regs[write.addr] <= write.data;
      end
   end

   // A write in the same cycle is forwarded so decode never sees a stale word
   assign hit1 = write.en && (write.addr == readAddr1);
   assign hit2 = write.en && (write.addr == readAddr2);

   assign readData1 = hit1 ? write.data : regs[readAddr1];
   assign readData2 = hit2 ? write.data : regs[readAddr2];

endmodule

`default_nettype wire

//--- hw/branchResolve.sv
// Branch condition evaluation and fetch redirect select for the decode stage
`default_nettype none

module branchResolve (
   input  logic [decodePkg::dataWidth-1:0] instr,
   input  logic [decodePkg::dataWidth-1:0] operand,
   input  decodePkg::ctrlT                 ctrl,
   output logic                            pcSel
);
   import decodePkg::*;

   logic       isBranch;  // Instruction sits in the branch group
   logic [1:0] cond;
   logic       isZero;
   logic       isNeg;     // Sign bit of Rs
   logic       condMet;

   assign isBranch = (instr[grpHi:grpLo] == branchGroup);
   assign cond     = instr[condHi:condLo];
   assign isZero   = (operand == '0);
   assign isNeg    = operand[dataWidth-1];

   always_comb begin
      unique case (cond)
         condEqz: condMet = isZero;   // Taken when Rs is zero
         condNez: condMet = !isZero;
         condLtz: condMet = isNeg;    // Negative in two's complement
         condGez: condMet = !isNeg;   // Zero counts as not negative
         default: condMet = 1'b0;
      endcase
   end

   // Halt and empty slots never redirect fetch
   assign pcSel = ctrl.valid && !ctrl.halt && (ctrl.jump || (isBranch && condMet));

endmodule

`default_nettype wire

//--- hw/pipeDelay.sv
// Generic pipeline delay line with advance, flush and a tap on its first stage
`default_nettype none

module pipeDelay #(
   parameter type payloadT = logic,
   parameter int  depth    = 1
) (
   input  logic    clk,
   input  logic    reset,
   input  logic    advance,
   input  logic    flush,
   input  payloadT din,
   output payloadT dout,
   output payloadT firstOut
);

   payloadT stages [depth];  // Stage 0 is the one right after the source

   // Flush has priority over advance so a squashed slot never moves on
   always_ff @(posedge clk) begin
      if (reset || flush) begin
         for (int i = 0; i < depth; i++) begin
            stages[i] <= '0;
         end
      end else if (advance) begin
         stages[0] <= din;
         for (int i = 1; i < depth; i++) begin
            stages[i] <= stages[i-1];  // Shift one stage further down
         end
      end
   end

   assign firstOut = stages[0];
   assign dout     = stages[depth-1];  // Oldest entry

endmodule

`default_nettype wire

//--- hw/decodeStage.sv
// Decode control with source selection, link tracking and write port arbitration
`default_nettype none

module decodeStage (
   input  logic                               clk,
   input  logic                               reset,
   input  logic [decodePkg::dataWidth-1:0]    instr,
   input  logic [decodePkg::dataWidth-1:0]    pcNow,
   input  decodePkg::ctrlT                    ctrl,
   input  decodePkg::wbT                      wb,
   input  logic                               advance,
   input  logic                               flush,
   output logic [decodePkg::regAddrWidth-1:0] readAddr1,
   output logic [decodePkg::regAddrWidth-1:0] readAddr2,
   output decodePkg::wbT                      rfWrite
);
   import decodePkg::*;

   logic [4:0]              opcode;
   logic [regAddrWidth-1:0] rs;
   logic [regAddrWidth-1:0] rt;
   logic                    isLink;      // Jump and link sitting in decode
   linkRecT                 linkIn;
   linkRecT                 linkFirst;   // Record one stage past decode
   linkRecT                 linkLast;    // Record at writeback
   logic [dataWidth-1:0]    returnAddr;
   logic [dataWidth-1:0]    returnAddrQ; // Return address of the record in stage 1
   logic                    linkWrite;

   assign opcode = instr[opHi:opLo];
   assign rs     = instr[rsHi:rsLo];
   assign rt     = instr[rtHi:rtLo];

   // The PC relative jump and link reads R7 on its first port
   assign readAddr1 = (opcode == opJal) ? linkReg : rs;
   assign readAddr2 = rt;

   assign isLink       = ctrl.valid && ((opcode == opJal) || (opcode == opJalr));
   assign linkIn.valid = isLink;

   // One record per stage from decode down to writeback
   pipeDelay #(
      .payloadT (linkRecT),
      .depth    (linkDepth)
   ) linkLine_i (
      .clk      (clk),
      .reset    (reset),
      .advance  (advance),
      .flush    (flush),
      .din      (linkIn),
      .dout     (linkLast),
      .firstOut (linkFirst)
   );

   assign returnAddr = pcNow + dataWidth'(2);  // Address of the next instruction

   // Captured on the same edge as the record it belongs to
   always_ff @(posedge clk) begin
      if (advance) begin
         returnAddrQ <= returnAddr;
      end
   end

   // R7 is written early, and only while the pipe moves
   assign linkWrite = linkFirst.valid && advance;

   always_comb begin
      rfWrite = wb;                // Normal writeback by default
      if (linkWrite) begin
         rfWrite.en   = 1'b1;      // Link write takes the port outright
         rfWrite.addr = linkReg;
         rfWrite.data = returnAddrQ;
      end else if (linkLast.valid) begin
         rfWrite.en = 1'b0;        // Late writeback of the same jump and link is dropped
      end
   end

endmodule

`default_nettype wire

//--- hw/decodeUnit.sv
// Decode unit top level joining the stage, register file, branch unit and decode/execute latch
`default_nettype none

module decodeUnit (
   input  logic                            clk,
   input  logic                            reset,
   input  logic [decodePkg::dataWidth-1:0] instr,
   input  logic [decodePkg::dataWidth-1:0] pcNow,
   input  logic [decodePkg::dataWidth-1:0] imm,
   input  decodePkg::ctrlT                 ctrl,
   input  decodePkg::wbT                   wb,
   input  logic                            advance,
   input  logic                            flush,
   output logic                            pcSel,
   output decodePkg::idExT                 idEx
);
   import decodePkg::*;

   logic [regAddrWidth-1:0] readAddr1;
   logic [regAddrWidth-1:0] readAddr2;
   wbT                      rfWrite;   // Arbitrated write request
   logic [dataWidth-1:0]    reg1Data;
   logic [dataWidth-1:0]    reg2Data;
   idExT                    idExNext;  // Payload entering the execute latch

   decodeStage decodeStage_i (
      .clk       (clk),
      .reset     (reset),
      .instr     (instr),
      .pcNow     (pcNow),
      .ctrl      (ctrl),
      .wb        (wb),
      .advance   (advance),
      .flush     (flush),
      .readAddr1 (readAddr1),
      .readAddr2 (readAddr2),
      .rfWrite   (rfWrite)
   );

   registerFile registerFile_i (
      .clk       (clk),
      .reset     (reset),
      .readAddr1 (readAddr1),
      .readAddr2 (readAddr2),
      .write     (rfWrite),
      .readData1 (reg1Data),
      .readData2 (reg2Data)
   );

   // Branches test the first operand, so a jump and link through R7 sees the bypass too
   branchResolve branchResolve_i (
      .instr   (instr),
      .operand (reg1Data),
      .ctrl    (ctrl),
      .pcSel   (pcSel)
   );

   assign idExNext.reg1Data = reg1Data;
   assign idExNext.reg2Data = reg2Data;
   assign idExNext.imm      = imm;
   assign idExNext.pcNow    = pcNow;
   assign idExNext.rt       = instr[rtHi:rtLo];
   assign idExNext.ctrl     = ctrl;

   // Single stage latch, the tap is the same stage as the output
   pipeDelay #(
      .payloadT (idExT),
      .depth    (1)
   ) idExLatch_i (
      .clk      (clk),
      .reset    (reset),
      .advance  (advance),
      .flush    (flush),
      .din      (idExNext),
      .dout     (idEx),
      .firstOut ()
   );

endmodule

`default_nettype wire

//--- verification/decodeUnit_properties.sv
// Concurrent assertions on link tracking and write port arbitration of the decode stage
`default_nettype none

module decodeUnit_properties (
   input logic               clk,
   input logic               reset,
   input logic               advance,
   input logic               flush,
   input decodePkg::linkRecT linkFirst,
   input decodePkg::linkRecT linkLast,
   input decodePkg::wbT      rfWrite
);
   import decodePkg::*;

   int failures = 0;  // Failed assertions so far, summed up at the end of the run

   // The late writeback of a jump and link never reaches the register file
   lateWbDropped: assert property (@(posedge clk) disable iff (reset)
      (linkLast.valid && !linkFirst.valid) |-> !rfWrite.en)
      else begin
         failures++;
         $error("Write port active while only the last link record is valid");
      end

   linkTargetsR7: assert property (@(posedge clk) disable iff (reset)
      (linkFirst.valid && advance) |-> (rfWrite.en && rfWrite.addr == linkReg))
      else begin
         failures++;
         $error("Link write does not target the link register");
      end

   flushClearsTaps: assert property (@(posedge clk) disable iff (reset)
      flush |=> (!linkFirst.valid && !linkLast.valid))
      else begin
         failures++;
         $error("Link record still valid after flush");
      end

   // The middle record surfaces at the last stage one advance later
   flushClearsMiddle: assert property (@(posedge clk) disable iff (reset)
      flush ##1 (advance && !flush) |=> !linkLast.valid)
      else begin
         failures++;
         $error("Middle link record survived a flush");
      end

endmodule

`default_nettype wire

//--- verification/decodeUnit_tb.sv
// Testbench for the decode unit with reset sweeps, link sequences and random stimulus against a model
`default_nettype none

module decodeUnit_tb;
   import decodePkg::*;

   localparam int clkPeriod    = 40;
   localparam int randomCycles = 800;
   localparam int testCycles   = randomCycles + 60;  // Resets, register sweeps and link sequences

   logic                 clk;
   logic                 reset;
   logic [dataWidth-1:0] instr;
   logic [dataWidth-1:0] pcNow;
   logic [dataWidth-1:0] imm;
   ctrlT                 ctrl;
   wbT                   wb;
   logic                 advance;
   logic                 flush;
   logic                 pcSel;
   idExT                 idEx;

   logic [dataWidth-1:0] modelRegs [regCount];  // Reference copy of the register file
   logic [linkDepth-1:0] modelLink;             // Bit 0 is the record just past decode
   logic [dataWidth-1:0] modelRet;              // Return address captured at the last advance
   idExT                 expIdEx;               // What the execute latch should hold now

   decodeUnit decodeUnit_i (
      .clk(clk), .reset(reset), .instr(instr), .pcNow(pcNow), .imm(imm),
      .ctrl(ctrl), .wb(wb), .advance(advance), .flush(flush),
      .pcSel(pcSel), .idEx(idEx)
   );

   // Link tracking rules are watched from inside the stage
   bind decodeStage decodeUnit_properties decodeStageProps_i (
      .clk(clk), .reset(reset), .advance(advance), .flush(flush),
      .linkFirst(linkFirst), .linkLast(linkLast), .rfWrite(rfWrite)
   );

   initial begin
      clk = 1'b0;
      forever #(clkPeriod / 2) clk = ~clk;
   end

   initial begin
      #((testCycles + 20) * clkPeriod);  // Whole test length plus some slack
      $display("Simulation timed out before the test sequence completed");
      $display("ERRORS FOUND");
      $fatal(1, "Watchdog expired");
   end

   task automatic checkValue(input logic [79:0] actual, input logic [79:0] expected,
                             input string what);
      if (actual !== expected) begin
         $display("** Error at time %0t: %s mismatch, got %h, expected %h",
                  $time, what, actual, expected);
         $display("ERRORS FOUND");
         $fatal(1, "Check failed");
      end
   endtask

   function automatic logic [dataWidth-1:0] buildInstr(input logic [4:0] op,
                                                       input logic [regAddrWidth-1:0] rs, rt);
      return {op, rs, rt, 5'b00000};  // Low five bits are unused by decode
   endfunction

   // Register read with the same cycle write forwarded
   function automatic logic [dataWidth-1:0] readModel(input logic [regAddrWidth-1:0] addr,
                                                      input wbT port);
      if (port.en && port.addr == addr) begin
         return port.data;
      end
      return modelRegs[addr];
   endfunction

   function automatic logic condHolds(input logic [1:0] cond, input logic [dataWidth-1:0] value);
      case (cond)
         condEqz: return value == '0;
         condNez: return value != '0;
         condLtz: return value[dataWidth-1];  // Sign bit set
         default: return !value[dataWidth-1];
      endcase
   endfunction

   task automatic applyReset();
      reset   = 1'b1;
      instr   = '0;
      pcNow   = '0;
      imm     = '0;
      ctrl    = '0;
      wb      = '0;
      advance = 1'b0;
      flush   = 1'b0;
      repeat (3) @(posedge clk);
      #5;
      reset = 1'b0;
      for (int i = 0; i < regCount; i++) begin
         modelRegs[i] = '0;
      end
      modelLink = '0;
      modelRet  = '0;
      expIdEx   = '0;  // Latch comes out of reset empty
   endtask

   // Drives one cycle, checks mid cycle and then moves the model across the edge
   task automatic stepCycle(input logic [dataWidth-1:0] instrV, pcV, immV,
                            input ctrlT ctrlV, input wbT wbV, input logic advV, flushV);
      wbT                      portWrite;  // Expected arbitrated write
      logic [4:0]              op;
      logic [regAddrWidth-1:0] src1;
      logic [dataWidth-1:0]    data1;
      logic [dataWidth-1:0]    data2;
      logic                    taken;
      idExT                    nextIdEx;
      instr   = instrV;
      pcNow   = pcV;
      imm     = immV;
      ctrl    = ctrlV;
      wb      = wbV;
      advance = advV;
      flush   = flushV;
      #15;
      op        = instrV[15:11];
      portWrite = wbV;
      if (modelLink[0] && advV) begin  // Early R7 write owns the port
         portWrite.en   = 1'b1;
         portWrite.addr = linkReg;
         portWrite.data = modelRet;
      end else if (modelLink[linkDepth-1]) begin
         portWrite.en = 1'b0;          // Writeback of a jump and link already in R7
      end
      src1  = (op == opJal) ? linkReg : instrV[10:8];
      data1 = readModel(src1, portWrite);
      data2 = readModel(instrV[7:5], portWrite);
      taken = ctrlV.valid && !ctrlV.halt &&
              (ctrlV.jump || (instrV[15:13] == branchGroup && condHolds(instrV[12:11], data1)));
      checkValue(pcSel, taken, "pcSel");
      checkValue(idEx, expIdEx, "idEx");
      nextIdEx.reg1Data = data1;
      nextIdEx.reg2Data = data2;
      nextIdEx.imm      = immV;
      nextIdEx.pcNow    = pcV;
      nextIdEx.rt       = instrV[7:5];
      nextIdEx.ctrl     = ctrlV;
      if (portWrite.en) begin
         modelRegs[portWrite.addr] = portWrite.data;
      end
      if (advV) begin
         modelRet = pcV + 16'd2;
      end
      if (flushV) begin
         modelLink = '0;
         expIdEx   = '0;
      end else if (advV) begin
         modelLink = {modelLink[linkDepth-2:0], ctrlV.valid && (op == opJal || op == opJalr)};
         expIdEx   = nextIdEx;
      end
      @(posedge clk);
      #5;
   endtask

   task automatic sweepRegisters();
      ctrlT readCtrl;
      readCtrl       = '0;
      readCtrl.valid = 1'b1;
      for (int i = 0; i <= regCount; i++) begin  // One extra step drains the last read
         stepCycle(buildInstr(5'b00000, 3'(i), 3'(regCount - 1 - i)), 16'(i), '0,
                   readCtrl, '0, 1'b1, 1'b0);
      end
   endtask

   task automatic linkSequence();
      ctrlT                 jalCtrl;
      ctrlT                 readCtrl;
      wbT                   lateWrite;
      logic [dataWidth-1:0] jalPc;
      logic [dataWidth-1:0] retAddr;
      jalCtrl          = '0;
      jalCtrl.valid    = 1'b1;
      jalCtrl.jump     = 1'b1;
      jalCtrl.regWrite = 1'b1;
      readCtrl         = '0;
      readCtrl.valid   = 1'b1;
      jalPc            = 16'($urandom);
      retAddr          = jalPc + 16'd2;
      lateWrite.en     = 1'b1;
      lateWrite.addr   = linkReg;
      lateWrite.data   = ~retAddr;  // Would clobber R7 if it got through
      stepCycle(buildInstr(opJal, 3'd0, 3'd0), jalPc, '0, jalCtrl, '0, 1'b1, 1'b0);
      repeat (2) stepCycle('0, '0, '0, '0, '0, 1'b1, 1'b0);
      stepCycle('0, '0, '0, '0, lateWrite, 1'b1, 1'b0);  // Lands linkDepth edges after decode
      stepCycle(buildInstr(5'b00000, linkReg, 3'd0), '0, '0, readCtrl, '0, 1'b1, 1'b0);
      checkValue(idEx.reg1Data, retAddr, "R7 after jump and link");
   endtask

   task automatic randomCycle();
      logic [dataWidth-1:0] instrV;
      ctrlT                 ctrlV;
      wbT                   wbV;
      instrV = 16'($urandom);
      case ($urandom % 4)
         0: instrV[15:11] = opJal;
         1: instrV[15:11] = opJalr;
         2: instrV[15:13] = branchGroup;  // Condition field stays random
         default: ;
      endcase
      ctrlV          = '0;
      ctrlV.valid    = ($urandom % 8) != 0;
      ctrlV.halt     = ($urandom % 8) == 0;
      ctrlV.jump     = ($urandom % 4) == 0;
      ctrlV.regWrite = ($urandom % 2) == 0;
      ctrlV.memRead  = ($urandom % 4) == 0;  // Memory flags only travel to execute
      ctrlV.memWrite = ($urandom % 4) == 0;
      wbV.en         = ($urandom % 2) == 0;
      wbV.addr       = 3'($urandom);
      wbV.data       = (($urandom % 4) == 0) ? '0 : 16'($urandom);  // Zero often for branches
      stepCycle(instrV, 16'($urandom), 16'($urandom), ctrlV, wbV,
                ($urandom % 5) != 0, ($urandom % 16) == 0);
   endtask

   initial begin
      void'($urandom(84));
      applyReset();
      sweepRegisters();
      repeat (4) linkSequence();
      repeat (randomCycles) randomCycle();
      applyReset();
      sweepRegisters();  // Every register must read zero again
      if (decodeUnit_i.decodeStage_i.decodeStageProps_i.failures == 0) begin
         $display("NO ERRORS");
         $finish;
      end else begin
         $display("Concurrent assertions failed during the run");
         $display("ERRORS FOUND");
         $fatal(1, "Assertion failures");
      end
   end

endmodule

`default_nettype wire

//--- verilog.f
hw/decodePkg.sv
hw/registerFile.sv
hw/branchResolve.sv
hw/pipeDelay.sv
hw/decodeStage.sv
hw/decodeUnit.sv
verification/decodeUnit_properties.sv
verification/decodeUnit_tb.sv

//--- Bender.yml
package:
  name: decode_unit

sources:
  - files:
      - hw/decodePkg.sv
      - hw/registerFile.sv
      - hw/branchResolve.sv
      - hw/pipeDelay.sv
      - hw/decodeStage.sv
      - hw/decodeUnit.sv
  - target: test
    files:
      - verification/decodeUnit_properties.sv
      - verification/decodeUnit_tb.sv

# Testbench top module is decodeUnit_tb, RTL top level is decodeUnit
